//--- hw/mapper_mmc1_top.sv
`timescale 1ns/1ps
`include "mmc1_consts.svh"

module mapper_mmc1_top
(
	input  logic cpu_m2,
	input  logic rst,
	input  logic [14:13] cpu_addr,
	input  logic cpu_d7,
	input  logic cpu_d0,
	input  logic cpu_ce_n,
	input  logic cpu_rw,
	input  logic [12:10] ppu_addr,

	input  logic sst_req,
	input  logic sst_we,
	input  logic [`SST_ADDR_W-1:0] sst_addr,
	input  logic [7:0] sst_wdata,
	output logic sst_ack,
	output logic [7:0] sst_rdata,

	output logic wram_ce,
	output logic prg_ce_n,
	output logic ciram_a10,
	output logic [`PRG_BANK_W-1:0] prg_addr,
	output logic [`CHR_BANK_W-1:0] chr_addr
);
	sst_if sst_bus();
	mmc1_load_if load_bus();
	mmc1_pkg::mmc1_regs_t regs;

	////////////////////////////////////////////////////////////
	// cpu serial path
	mmc1_serial_loader loader_i
	(
		.cpu_m2   (cpu_m2),
		.rst      (rst),
		.cpu_ce_n (cpu_ce_n),
		.cpu_rw   (cpu_rw),
		.cpu_d0   (cpu_d0),
		.cpu_d7   (cpu_d7),
		.cpu_addr (cpu_addr),
		.sst_act  (sst_bus.act),
		.load     (load_bus.loader)
	);

	mmc1_reg_file reg_file_i
	(
		.cpu_m2 (cpu_m2),
		.rst    (rst),
		.load   (load_bus.regs),
		.sst    (sst_bus.regs),
		.regs   (regs)
	);

	// save-state handshake
	sst_bridge bridge_i
	(
		.cpu_m2    (cpu_m2),
		.rst       (rst),
		.sst_req   (sst_req),
		.sst_we    (sst_we),
		.sst_addr  (sst_addr),
		.sst_wdata (sst_wdata),
		.sst_ack   (sst_ack),
		.sst_rdata (sst_rdata),
		.sst       (sst_bus.bridge)
	);

	mmc1_addr_map addr_map_i
	(
		.regs      (regs),
		.cpu_addr  (cpu_addr),
		.cpu_ce_n  (cpu_ce_n),
		.cpu_rw    (cpu_rw),
		.ppu_addr  (ppu_addr),
		.wram_ce   (wram_ce),
		.prg_ce_n  (prg_ce_n),
		.ciram_a10 (ciram_a10),
		.prg_addr  (prg_addr),
		.chr_addr  (chr_addr)
	);

endmodule

//--- hw/mmc1_addr_map.sv
`timescale 1ns/1ps
`include "mmc1_consts.svh"

module mmc1_addr_map
(
	input  mmc1_pkg::mmc1_regs_t regs,
	input  logic [14:13] cpu_addr,
	input  logic cpu_ce_n,
	input  logic cpu_rw,
	input  logic [12:10] ppu_addr,
	output logic wram_ce,
	output logic prg_ce_n,
	output logic ciram_a10,
	output logic [`PRG_BANK_W-1:0] prg_addr,
	output logic [`CHR_BANK_W-1:0] chr_addr
);
	assign wram_ce  = cpu_ce_n && cpu_addr == 2'b11 && !regs.prg[4];
	assign prg_ce_n = !(!cpu_ce_n && cpu_rw);

	// one-screen or vertical/horizontal mirroring
	assign ciram_a10 = !regs.control[1] ? regs.control[0] :
		(regs.control[0] ? ppu_addr[11] : ppu_addr[10]);

	always_comb
	begin
		if (!regs.control[3])
			prg_addr = {regs.prg[3:1], cpu_addr[14]};
		else if (!regs.control[2])
			prg_addr = cpu_addr[14] ? regs.prg[3:0] : '0;
		else
			prg_addr = cpu_addr[14] ? '1 : regs.prg[3:0];
	end

	////////////////////////////////////////////////////////////
	// chr, 8k or two 4k banks
	always_comb
	begin
		if (!regs.control[4])
			chr_addr = {regs.chr0[4:1], ppu_addr[12]};
		else if (!ppu_addr[12])
			chr_addr = regs.chr0;
		else
			chr_addr = regs.chr1;
	end

endmodule

//--- hw/mmc1_consts.svh
`ifndef MMC1_CONSTS_SVH
`define MMC1_CONSTS_SVH

// mapper register and shift register width
`define MMC1_REG_W 5

// save-state port
`define SST_ADDR_W 8
`define SST_NUM_REGS 5

// bank line widths, prg_addr[17:14] and chr_addr[16:12]
`define PRG_BANK_W 4
`define CHR_BANK_W 5

`endif

//--- hw/mmc1_load_if.sv
`timescale 1ns/1ps
`include "mmc1_consts.svh"

interface mmc1_load_if;
	logic load;
	mmc1_pkg::mmc1_reg_e sel;
	logic [`MMC1_REG_W-1:0] data;
	logic abort;
	logic [`MMC1_REG_W-1:0] shift;
	// save-state restore back into the loader
	logic shift_wr;
	logic [`MMC1_REG_W-1:0] shift_val;

	modport loader (output load, sel, data, abort, shift, input shift_wr, shift_val);

	modport regs (input load, sel, data, abort, shift, output shift_wr, shift_val);
endinterface

//--- hw/mmc1_pkg.sv
`include "mmc1_consts.svh"

package mmc1_pkg;

	// shared by save-state addresses and serial target codes
	typedef enum logic [2:0]
	{
		reg_control = 3'd0,
		reg_chr0    = 3'd1,
		reg_chr1    = 3'd2,
		reg_prg     = 3'd3,
		reg_shift   = 3'd4
	} mmc1_reg_e;

	// four-phase handshake bridge
	typedef enum logic [1:0]
	{
		sst_idle,
		sst_access,
		sst_hold
	} sst_state_e;

	typedef struct packed
	{
		logic [`MMC1_REG_W-1:0] control;
		logic [`MMC1_REG_W-1:0] chr0;
		logic [`MMC1_REG_W-1:0] chr1;
		logic [`MMC1_REG_W-1:0] prg;
	} mmc1_regs_t;

endpackage

//--- hw/mmc1_reg_file.sv
`timescale 1ns/1ps
`include "mmc1_consts.svh"

module mmc1_reg_file
(
	input  logic cpu_m2,
	input  logic rst,
	mmc1_load_if.regs load,
	sst_if.regs sst,
	output mmc1_pkg::mmc1_regs_t regs
);
	logic sst_wr;
	logic [`MMC1_REG_W-1:0] sst_val;
	logic [`MMC1_REG_W-1:0] rd_val;

	assign sst_wr  = sst.act && sst.we_reg;
	assign sst_val = sst.dato[`MMC1_REG_W-1:0];

	always_ff @(posedge cpu_m2)
	begin
		if (rst)
		begin
			regs.control <= 5'b11111;
			regs.chr0    <= '0;
			regs.chr1    <= '0;
			// prg bit 4 low, work ram enabled
			regs.prg     <= '0;
		end
		else if (sst_wr)
		begin
			case (sst.addr)
				`SST_ADDR_W'(mmc1_pkg::reg_control): regs.control <= sst_val;
				`SST_ADDR_W'(mmc1_pkg::reg_chr0):    regs.chr0    <= sst_val;
				`SST_ADDR_W'(mmc1_pkg::reg_chr1):    regs.chr1    <= sst_val;
				`SST_ADDR_W'(mmc1_pkg::reg_prg):     regs.prg     <= sst_val;
				default: ;
			endcase
		end
		else if (load.load)
		begin
			case (load.sel)
				mmc1_pkg::reg_control: regs.control <= load.data;
				mmc1_pkg::reg_chr0:    regs.chr0    <= load.data;
				mmc1_pkg::reg_chr1:    regs.chr1    <= load.data;
				mmc1_pkg::reg_prg:     regs.prg     <= load.data;
				default: ;
			endcase
		end
		else if (load.abort)
			regs.control[3:2] <= 2'b11;
	end

	// shift register lives in the loader
	assign load.shift_wr  = sst_wr && sst.addr == `SST_ADDR_W'(mmc1_pkg::reg_shift);
	assign load.shift_val = sst_val;

	////////////////////////////////////////////////////////////
	// save-state read mux
	always_comb
	begin
		case (sst.addr)
			`SST_ADDR_W'(mmc1_pkg::reg_control): rd_val = regs.control;
			`SST_ADDR_W'(mmc1_pkg::reg_chr0):    rd_val = regs.chr0;
			`SST_ADDR_W'(mmc1_pkg::reg_chr1):    rd_val = regs.chr1;
			`SST_ADDR_W'(mmc1_pkg::reg_prg):     rd_val = regs.prg;
			default:                             rd_val = load.shift;
		endcase
	end

	assign sst.di = (sst.addr < `SST_ADDR_W'(`SST_NUM_REGS)) ?
		{{(8 - `MMC1_REG_W){1'b0}}, rd_val} : 8'hff;

	// one act pulse per access
	a_act_pulse: assert property (@(posedge cpu_m2) disable iff (rst)
		sst.act |=> !sst.act)
		else $error("save-state act held for more than one cycle");

endmodule

//--- hw/mmc1_serial_loader.sv
`timescale 1ns/1ps
`include "mmc1_consts.svh"

module mmc1_serial_loader
(
	input  logic cpu_m2,
	input  logic rst,
	input  logic cpu_ce_n,
	input  logic cpu_rw,
	input  logic cpu_d0,
	input  logic cpu_d7,
	input  logic [14:13] cpu_addr,
	input  logic sst_act,
	mmc1_load_if.loader load
);
	logic rw_q;
	logic [2:0] bit_cnt;
	logic [`MMC1_REG_W-1:0] shift_q;
	logic [`MMC1_REG_W-1:0] shift_next;
	logic wr_ok;
	logic last_bit;

	// back-to-back writes and writes under a save-state access are dropped
	assign wr_ok = !cpu_ce_n && !cpu_rw && rw_q && !sst_act;
	assign shift_next = {cpu_d0, shift_q[`MMC1_REG_W-1:1]};
	assign last_bit = bit_cnt == 3'(`MMC1_REG_W - 1);

	always_ff @(posedge cpu_m2)
	begin
		if (rst)
			rw_q <= 1'b1;
		else
			rw_q <= cpu_rw;
	end

	always_ff @(posedge cpu_m2)
	begin
		if (rst)
		begin
			bit_cnt <= 3'd0;
			shift_q <= '0;
		end
		else if (load.shift_wr)
			shift_q <= load.shift_val;
		else if (wr_ok)
		begin
			if (cpu_d7)
				bit_cnt <= 3'd0;
			else
			begin
				shift_q <= shift_next;
				bit_cnt <= last_bit ? 3'd0 : bit_cnt + 3'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// load pulse is sampled by the register file on this edge
	assign load.load  = wr_ok && !cpu_d7 && last_bit;
	assign load.sel   = mmc1_pkg::mmc1_reg_e'({1'b0, cpu_addr});
	assign load.data  = shift_next;
	assign load.abort = wr_ok && cpu_d7;
	assign load.shift = shift_q;

	// restore has priority over a cpu write and needs act to keep them apart
	a_restore_in_act: assert property (@(posedge cpu_m2) disable iff (rst)
		load.shift_wr |-> sst_act)
		else $error("shift restore outside a save-state access");

endmodule

//--- hw/sst_bridge.sv
`timescale 1ns/1ps
`include "mmc1_consts.svh"

module sst_bridge
(
	input  logic cpu_m2,
	input  logic rst,
	input  logic sst_req,
	input  logic sst_we,
	input  logic [`SST_ADDR_W-1:0] sst_addr,
	input  logic [7:0] sst_wdata,
	output logic sst_ack,
	output logic [7:0] sst_rdata,
	sst_if.bridge sst
);
	mmc1_pkg::sst_state_e state;

	always_ff @(posedge cpu_m2)
	begin
		if (rst)
			state <= mmc1_pkg::sst_idle;
		else
		begin
			case (state)
				mmc1_pkg::sst_idle:
				begin
					if (sst_req)
						state <= mmc1_pkg::sst_access;
				end
				mmc1_pkg::sst_access:
					state <= mmc1_pkg::sst_hold;
				mmc1_pkg::sst_hold:
				begin
					// wait for the controller to release req
					if (!sst_req)
						state <= mmc1_pkg::sst_idle;
				end
				default:
					state <= mmc1_pkg::sst_idle;
			endcase
		end
	end

	// read data latched on the access cycle
	always_ff @(posedge cpu_m2)
	begin
		if (state == mmc1_pkg::sst_access)
			sst_rdata <= sst.di;
	end

	assign sst.act    = state == mmc1_pkg::sst_access;
	assign sst.we_reg = sst_we;
	assign sst.addr   = sst_addr;
	assign sst.dato   = sst_wdata;
	assign sst_ack    = state == mmc1_pkg::sst_hold;

	a_ack_needs_req: assert property (@(posedge cpu_m2) disable iff (rst)
		$rose(sst_ack) |-> $past(sst_req))
		else $error("ack raised without req");

endmodule

//--- hw/sst_if.sv
`timescale 1ns/1ps
`include "mmc1_consts.svh"

// one-cycle save-state access, bridge to register file
interface sst_if;
	logic act;
	logic we_reg;
	logic [`SST_ADDR_W-1:0] addr;
	logic [7:0] dato;
	logic [7:0] di;

	modport bridge
	(
		output act, we_reg, addr, dato,
		input  di
	);

	modport regs
	(
		input  act, we_reg, addr, dato,
		output di
	);
endinterface

//--- run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module mapper_mmc1_tb \
	-f verilog.f -Mdir obj_dir -o mmc1_sim \
	&& ./obj_dir/mmc1_sim | tee sim.log
grep -qx "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- verification/mapper_mmc1_tb.sv
`timescale 1ns/1ps
`include "mmc1_consts.svh"

module mapper_mmc1_tb;
	localparam int num_loads = 200;
	localparam int sweep_len = 33;
	localparam int load_len = 10;
	// twice the expected length, the random loads plus about 20 load-sized steps
	localparam int cycle_limit = 2 * (16 + (num_loads + 20) * (load_len + sweep_len));

	logic cpu_m2;
	logic rst;
	logic [14:13] cpu_addr;
	logic cpu_d7;
	logic cpu_d0;
	logic cpu_ce_n;
	logic cpu_rw;
	logic [12:10] ppu_addr;
	logic sst_req;
	logic sst_we;
	logic [`SST_ADDR_W-1:0] sst_addr;
	logic [7:0] sst_wdata;
	logic sst_ack;
	logic [7:0] sst_rdata;
	logic wram_ce;
	logic prg_ce_n;
	logic ciram_a10;
	logic [`PRG_BANK_W-1:0] prg_addr;
	logic [`CHR_BANK_W-1:0] chr_addr;

	// control, chr0, chr1, prg, shift
	logic [4:0] m_regs [0:4];
	int m_cnt;
	logic last_rw;
	logic sweep_on;
	int errors;
	int test_start_errors;
	int tests_passed;
	int tests_failed;
	int cycles;

	mapper_mmc1_top mapper_mmc1_i
	(
		.cpu_m2    (cpu_m2),
		.rst       (rst),
		.cpu_addr  (cpu_addr),
		.cpu_d7    (cpu_d7),
		.cpu_d0    (cpu_d0),
		.cpu_ce_n  (cpu_ce_n),
		.cpu_rw    (cpu_rw),
		.ppu_addr  (ppu_addr),
		.sst_req   (sst_req),
		.sst_we    (sst_we),
		.sst_addr  (sst_addr),
		.sst_wdata (sst_wdata),
		.sst_ack   (sst_ack),
		.sst_rdata (sst_rdata),
		.wram_ce   (wram_ce),
		.prg_ce_n  (prg_ce_n),
		.ciram_a10 (ciram_a10),
		.prg_addr  (prg_addr),
		.chr_addr  (chr_addr)
	);

	initial
	begin
		cpu_m2 = 1'b0;
		forever #2 cpu_m2 = ~cpu_m2;
	end

	always @(posedge cpu_m2)
	begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit)
		begin
			$display("timeout: the tests did not finish within %0d clock cycles", cycle_limit);
			$display("Done: errors found");
			$finish;
		end
	end

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t ns: %s: got 0x%0h, expected 0x%0h", $time, what, actual,
				expected);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// reference model

	// {wram_ce, prg_ce_n, ciram_a10, prg_addr, chr_addr}
	function automatic logic [11:0] decode_ref(input logic [4:0] ctrl, input logic [4:0] chr0,
		input logic [4:0] chr1, input logic [4:0] prg, input logic [14:13] ca,
		input logic [12:10] pa, input logic ce_n, input logic rw);
		logic w;
		logic ce;
		logic a10;
		logic [3:0] pbank;
		logic [4:0] cbank;
		w = ce_n && ca == 2'b11 && !prg[4];
		ce = !(rw && !ce_n);
		if (!ctrl[1])
			a10 = ctrl[0];
		else if (!ctrl[0])
			a10 = pa[10];
		else
			a10 = pa[11];
		// 32k mode, then fixed low bank, then fixed high bank
		if (!ctrl[3])
			pbank = {prg[3:1], ca[14]};
		else if (!ctrl[2])
			pbank = ca[14] ? prg[3:0] : 4'd0;
		else
			pbank = ca[14] ? 4'd15 : prg[3:0];
		if (!ctrl[4])
			cbank = {chr0[4:1], pa[12]};
		else
			cbank = pa[12] ? chr1 : chr0;
		return {w, ce, a10, pbank, cbank};
	endfunction

	function automatic logic [7:0] expected_read(input logic [7:0] addr);
		if (addr < 8'd5)
			return {3'b000, m_regs[addr[2:0]]};
		return 8'hff;
	endfunction

	task automatic apply_write(input logic d0, input logic d7, input logic [1:0] sel);
		if (d7)
		begin
			m_cnt = 0;
			m_regs[0][3:2] = 2'b11;
		end
		else
		begin
			m_regs[4] = {d0, m_regs[4][4:1]};
			if (m_cnt == 4)
			begin
				m_regs[{1'b0, sel}] = m_regs[4];
				m_cnt = 0;
			end
			else
				m_cnt++;
		end
	endtask

	// outputs sampled at the rising edge, inputs settled since the falling edge
	always @(posedge cpu_m2)
	begin
		if (sweep_on)
			check(32'({wram_ce, prg_ce_n, ciram_a10, prg_addr, chr_addr}),
				32'(decode_ref(m_regs[0], m_regs[1], m_regs[2], m_regs[3], cpu_addr,
				ppu_addr, cpu_ce_n, cpu_rw)), "decoded outputs");
	end

	////////////////////////////////////////////////////////////
	// stimulus

	task automatic drive_cycle(input logic ce_n, input logic rw, input logic d0,
		input logic d7, input logic [1:0] sel);
		@(negedge cpu_m2);
		cpu_ce_n = ce_n;
		cpu_rw = rw;
		cpu_d0 = d0;
		cpu_d7 = d7;
		cpu_addr = sel;
		// only a write after a read cycle counts
		if (!ce_n && !rw && last_rw)
			apply_write(d0, d7, sel);
		last_rw = rw;
	endtask

	task automatic cpu_serial_write(input logic [1:0] sel, input logic [4:0] value);
		for (int i = 0; i < 5; i++)
		begin
			drive_cycle(1'b0, 1'b0, value[i], 1'b0, sel);
			drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, sel);
		end
	endtask

	// every cpu_addr and ppu_addr pair with ce_n and rw varied
	// rw goes low a cycle ahead of each write so the loader drops it
	task automatic sweep_outputs();
		for (int i = 0; i < 32; i++)
		begin
			@(negedge cpu_m2);
			{cpu_addr, ppu_addr} = 5'(i);
			cpu_ce_n = i[0] ^ i[1];
			cpu_rw = !i[1];
			sweep_on = 1'b1;
		end
		@(negedge cpu_m2);
		cpu_ce_n = 1'b1;
		cpu_rw = 1'b1;
		sweep_on = 1'b0;
		last_rw = 1'b1;
	endtask

	task automatic sst_access(input logic we, input logic [7:0] addr, input logic [7:0] wdata,
		output logic [7:0] rdata);
		int waited;
		@(negedge cpu_m2);
		cpu_ce_n = 1'b1;
		cpu_rw = 1'b1;
		last_rw = 1'b1;
		sst_req = 1'b1;
		sst_we = we;
		sst_addr = addr;
		sst_wdata = wdata;
		waited = 0;
		while (!sst_ack)
		begin
			@(negedge cpu_m2);
			waited++;
		end
		check(32'(waited), 32'd2, "cycles from req to ack");
		rdata = sst_rdata;
		sst_req = 1'b0;
		if (we && addr < 8'd5)
			m_regs[addr[2:0]] = wdata[4:0];
		while (sst_ack)
			@(negedge cpu_m2);
	endtask

	task automatic end_test(input string name);
		if (errors == test_start_errors)
		begin
			tests_passed++;
			$display("test %s: passed", name);
		end
		else
		begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - test_start_errors);
		end
		test_start_errors = errors;
	endtask

	initial
	begin
		logic [7:0] rd;
		logic [4:0] val;
		logic [2:0] tail;
		logic [4:0] old_prg;
		void'($urandom(32'hef26596a));
		rst = 1'b1;
		cpu_addr = 2'd0;
		cpu_d7 = 1'b0;
		cpu_d0 = 1'b0;
		cpu_ce_n = 1'b1;
		cpu_rw = 1'b1;
		ppu_addr = 3'd0;
		sst_req = 1'b0;
		sst_we = 1'b0;
		sst_addr = '0;
		sst_wdata = 8'd0;
		m_regs[0] = 5'b11111;
		for (int r = 1; r < 5; r++)
			m_regs[r] = 5'd0;
		m_cnt = 0;
		last_rw = 1'b1;
		sweep_on = 1'b0;
		errors = 0;
		test_start_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		cycles = 0;
		repeat (16) @(negedge cpu_m2);
		rst = 1'b0;

		check(32'(sst_ack), 32'd0, "sst_ack after reset");
		sweep_outputs();
		end_test("reset defaults");

		for (int n = 0; n < num_loads; n++)
		begin
			cpu_serial_write(2'($urandom()), 5'($urandom()));
			sweep_outputs();
		end
		end_test("random serial loads");

		// abort in the middle of a sequence, prg mode 0 before it
		cpu_serial_write(2'd0, 5'b10011);
		drive_cycle(1'b0, 1'b0, 1'b1, 1'b0, 2'd1);
		drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, 2'd1);
		drive_cycle(1'b0, 1'b0, 1'b1, 1'b0, 2'd1);
		drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, 2'd1);
		drive_cycle(1'b0, 1'b0, 1'b0, 1'b1, 2'd1);
		drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, 2'd1);
		sweep_outputs();
		sst_access(1'b0, 8'd0, 8'd0, rd);
		check(32'(rd), 32'h1f, "control after abort");
		val = 5'($urandom());
		cpu_serial_write(2'd1, val);
		sweep_outputs();
		sst_access(1'b0, 8'd1, 8'd0, rd);
		check(32'(rd), 32'(val), "chr0 loaded after abort");
		end_test("abort");

		// the write right after the third one is dropped
		old_prg = m_regs[3];
		val = 5'($urandom());
		drive_cycle(1'b0, 1'b0, val[0], 1'b0, 2'd3);
		drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, 2'd3);
		drive_cycle(1'b0, 1'b0, val[1], 1'b0, 2'd3);
		drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, 2'd3);
		drive_cycle(1'b0, 1'b0, val[2], 1'b0, 2'd3);
		drive_cycle(1'b0, 1'b0, !val[2], 1'b0, 2'd3);
		drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, 2'd3);
		drive_cycle(1'b0, 1'b0, val[3], 1'b0, 2'd3);
		drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, 2'd3);
		sst_access(1'b0, 8'd3, 8'd0, rd);
		check(32'(rd), 32'(old_prg), "prg after four accepted writes");
		drive_cycle(1'b0, 1'b0, val[4], 1'b0, 2'd3);
		drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, 2'd3);
		sweep_outputs();
		sst_access(1'b0, 8'd3, 8'd0, rd);
		check(32'(rd), 32'(val), "prg after the fifth accepted write");
		end_test("back-to-back write");

		for (int a = 0; a < 5; a++)
		begin
			sst_access(1'b1, 8'(a), 8'($urandom()), rd);
			sweep_outputs();
		end
		for (int a = 0; a < 6; a++)
		begin
			sst_access(1'b0, (a == 5) ? 8'd9 : 8'(a), 8'd0, rd);
			check(32'(rd), 32'(expected_read((a == 5) ? 8'd9 : 8'(a))), "save-state read");
		end
		// restore the shift register with two bits already counted
		val = 5'($urandom());
		tail = 3'($urandom());
		cpu_serial_write(2'd3, 5'($urandom()));
		drive_cycle(1'b0, 1'b0, 1'b1, 1'b0, 2'd3);
		drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, 2'd3);
		drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, 2'd3);
		drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, 2'd3);
		sst_access(1'b1, 8'd4, {3'b000, val}, rd);
		for (int i = 0; i < 3; i++)
		begin
			drive_cycle(1'b0, 1'b0, tail[i], 1'b0, 2'd3);
			drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, 2'd3);
		end
		sweep_outputs();
		sst_access(1'b0, 8'd3, 8'd0, rd);
		check(32'(rd), 32'({tail[2], tail[1], tail[0], val[4:3]}), "prg after shift restore");
		end_test("save-state port");

		$display("tests passed %0d, tests failed %0d, errors %0d", tests_passed, tests_failed,
			errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+hw
hw/mmc1_pkg.sv
hw/sst_if.sv
hw/mmc1_load_if.sv
hw/mmc1_serial_loader.sv
hw/mmc1_reg_file.sv
hw/sst_bridge.sv
hw/mmc1_addr_map.sv
hw/mapper_mmc1_top.sv
verification/mapper_mmc1_tb.sv
